/* egr_tqu.f */
+incdir+include
hdl/egr_rrsp_pkg.sv
hdl/egr_buf_pkg.sv
hdl/tqu_mem_bank.sv
hdl/tqu_rrsp_rcv.sv
hdl/tqu_queue_ctrl.sv
hdl/tqu.sv
hdl/egr_tqu_top.sv
tests/tb_tqu.sv

/* Makefile */
# Verilator build and run of the tag queuing stage testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build tb_tqu with Verilator, run it, look for the pass message in $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_tqu -Mdir obj_dir -o sim_tqu -f egr_tqu.f
	./obj_dir/sim_tqu | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tests/tb_tqu.sv */
`timescale 1ns/1ps
`include "egr_tqu_defines.svh"

module tb_tqu;
    import egr_rrsp_pkg::*;

    localparam int N_Q          = `EGR_N_DTQ;
    localparam int RST_CYCLES   = 10;
    localparam int MIX1_CYCLES  = 1500;
    localparam int FILL_CYCLES  = 150;
    localparam int MIX2_CYCLES  = 1000;
    localparam int DRAIN_CYCLES = 100;
    localparam int TOTAL_CYCLES = RST_CYCLES + MIX1_CYCLES + FILL_CYCLES
                                  + MIX2_CYCLES + DRAIN_CYCLES + 4;
    // 4 ns period, twice the planned length
    localparam int WATCHDOG_NS  = 4 * TOTAL_CYCLES * 2;

    logic                  clk;
    logic                  rst_n;
    logic                  rrsp_wd_valid;
    data_word_t            rrsp_wd;
    word_type_e            rrsp_wd_type;
    dtq_sel_t              rrsp_dtq;
    logic                  rrsp_wd_stall;
    logic                  ctrl_pull;
    dtq_sel_t              ctrl_sel;
    logic                  data_pull;
    dtq_sel_t              data_sel;
    logic [N_Q-1:0]        ctrl_ready;
    logic [N_Q-1:0]        data_ready;
    data_word_t            ctrl_word;
    data_word_t            data_word;
    logic                  ctrl_word_valid;
    logic                  data_word_valid;

    // --------------------
    // model state
    // --------------------
    // index is bank * N_Q + queue, bank 0 control, bank 1 data
    data_word_t exp_words [2*N_Q][$];
    // occupancy as the DUT should see it, lags acceptance by one edge
    int         cnt_model [2*N_Q];
    logic [31:0] lcg_state;
    // word on offer, held until accepted
    bit         offering;
    int         offer_bank;
    int         offer_q;
    data_word_t offer_word;
    logic       stall_at_drive;
    // write strobe in flight
    bit         pend_valid;
    int         pend_idx;
    // pulls driven for the coming edge
    bit         ctrl_pulled;
    bit         data_pulled;
    int         ctrl_pull_q;
    int         data_pull_q;
    data_word_t exp_ctrl;
    data_word_t exp_data;
    bit         stall_seen;
    int         mismatch_cnt;
    int         other_cnt;
    int         words_checked;
    int         same_q_pulls;
    int         diff_q_pulls;

    egr_tqu_top DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .rrsp_wd_valid   (rrsp_wd_valid),
        .rrsp_wd         (rrsp_wd),
        .rrsp_wd_type    (rrsp_wd_type),
        .rrsp_dtq        (rrsp_dtq),
        .rrsp_wd_stall   (rrsp_wd_stall),
        .ctrl_pull       (ctrl_pull),
        .ctrl_sel        (ctrl_sel),
        .data_pull       (data_pull),
        .data_sel        (data_sel),
        .ctrl_ready      (ctrl_ready),
        .data_ready      (data_ready),
        .ctrl_word       (ctrl_word),
        .data_word       (data_word),
        .ctrl_word_valid (ctrl_word_valid),
        .data_word_valid (data_word_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // --------------------
    // helpers
    // --------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits of the lcg are the better mixed ones
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'((r >> 8) % 32'(n));
    endfunction

    // first queue at or after start that the model shows ready, -1 if none
    function automatic int pick_ready(input int bank, input int start);
        int idx;
        for (int i = 0; i < N_Q; i++) begin
            idx = (start + i) % N_Q;
            if (cnt_model[bank*N_Q + idx] > 0) begin
                return idx;
            end
        end
        return -1;
    endfunction

    function automatic bit model_empty();
        for (int i = 0; i < 2*N_Q; i++) begin
            if (cnt_model[i] != 0 || exp_words[i].size() != 0) begin
                return 1'b0;
            end
        end
        return !offering && !pend_valid;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    // --------------------
    // per cycle drive and check
    // --------------------
    // runs at a falling edge, sets inputs for the next rising edge
    task automatic drive_inputs(input int offer_pct, input int pull_pct);
        int q;
        stall_at_drive = rrsp_wd_stall;
        if (!offering && rand_below(100) < offer_pct) begin
            offering   = 1'b1;
            offer_bank = rand_below(2);
            offer_q    = rand_below(N_Q);
            offer_word = {lcg_next(), lcg_next()};
        end
        rrsp_wd_valid = offering;
        rrsp_wd_type  = word_type_e'(offer_bank[0]);
        rrsp_dtq      = dtq_sel_t'(offer_q);
        rrsp_wd       = offer_word;
        ctrl_pulled   = 1'b0;
        data_pulled   = 1'b0;
        // control pull
        q = pick_ready(0, rand_below(N_Q));
        if (q >= 0 && rand_below(100) < pull_pct) begin
            ctrl_pulled = 1'b1;
            ctrl_pull_q = q;
            exp_ctrl    = exp_words[q].pop_front();
            ctrl_sel    = dtq_sel_t'(q);
        end
        // data pull, leaning toward the control queue now and then
        if (ctrl_pulled && rand_below(2) == 0 && cnt_model[N_Q + ctrl_pull_q] > 0) begin
            q = ctrl_pull_q;
        end else begin
            q = pick_ready(1, rand_below(N_Q));
        end
        if (q >= 0 && rand_below(100) < pull_pct) begin
            data_pulled = 1'b1;
            data_pull_q = q;
            exp_data    = exp_words[N_Q + q].pop_front();
            data_sel    = dtq_sel_t'(q);
        end
        ctrl_pull = ctrl_pulled;
        data_pull = data_pulled;
        if (ctrl_pulled && data_pulled) begin
            if (ctrl_pull_q == data_pull_q) begin
                same_q_pulls++;
            end else begin
                diff_q_pulls++;
            end
        end
    endtask

    // runs at the falling edge after the rising edge just taken
    task automatic update_and_check();
        logic [N_Q-1:0] exp_rdy_c;
        logic [N_Q-1:0] exp_rdy_d;
        // strobe from last acceptance wrote the bank at this edge
        if (pend_valid) begin
            cnt_model[pend_idx]++;
        end
        pend_valid = 1'b0;
        if (ctrl_pulled) begin
            cnt_model[ctrl_pull_q]--;
        end
        if (data_pulled) begin
            cnt_model[N_Q + data_pull_q]--;
        end
        // accepted when stall was low ahead of the edge
        if (offering && !stall_at_drive) begin
            pend_idx = offer_bank*N_Q + offer_q;
            exp_words[pend_idx].push_back(offer_word);
            pend_valid = 1'b1;
            offering   = 1'b0;
        end
        // pulled words, one cycle after the pull
        check_value("ctrl_word_valid", 64'(ctrl_pulled), 64'(ctrl_word_valid));
        check_value("data_word_valid", 64'(data_pulled), 64'(data_word_valid));
        if (ctrl_pulled) begin
            check_value("ctrl_word", exp_ctrl, ctrl_word);
            words_checked++;
        end
        if (data_pulled) begin
            check_value("data_word", exp_data, data_word);
            words_checked++;
        end
        for (int i = 0; i < N_Q; i++) begin
            exp_rdy_c[i] = (cnt_model[i] != 0);
            exp_rdy_d[i] = (cnt_model[N_Q + i] != 0);
        end
        check_value("ctrl_ready", 64'(exp_rdy_c), 64'(ctrl_ready));
        check_value("data_ready", 64'(exp_rdy_d), 64'(data_ready));
        for (int i = 0; i < 2*N_Q; i++) begin
            if (cnt_model[i] > `EGR_Q_DEPTH) begin
                other_cnt++;
                $display("queue %0d holds %0d words, more than its depth at %0t",
                         i, cnt_model[i], $time);
            end
        end
        if (rrsp_wd_stall) begin
            stall_seen = 1'b1;
        end
    endtask

    task automatic step(input int offer_pct, input int pull_pct);
        drive_inputs(offer_pct, pull_pct);
        @(negedge clk);
        update_and_check();
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        rst_n         = 1'b0;
        rrsp_wd_valid = 1'b0;
        rrsp_wd       = '0;
        rrsp_wd_type  = WORD_TYPE_CTRL;
        rrsp_dtq      = '0;
        ctrl_pull     = 1'b0;
        ctrl_sel      = '0;
        data_pull     = 1'b0;
        data_sel      = '0;
        lcg_state     = 32'hccdf_57d9;
        offering      = 1'b0;
        offer_bank    = 0;
        offer_q       = 0;
        offer_word    = '0;
        pend_valid    = 1'b0;
        pend_idx      = 0;
        ctrl_pulled   = 1'b0;
        data_pulled   = 1'b0;
        ctrl_pull_q   = 0;
        data_pull_q   = 0;
        mismatch_cnt  = 0;
        other_cnt     = 0;
        words_checked = 0;
        same_q_pulls  = 0;
        diff_q_pulls  = 0;
        for (int i = 0; i < 2*N_Q; i++) begin
            cnt_model[i] = 0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // idle state out of reset
        check_value("rrsp_wd_stall", 64'(0), 64'(rrsp_wd_stall));
        check_value("ctrl_ready", 64'(0), 64'(ctrl_ready));
        check_value("data_ready", 64'(0), 64'(data_ready));
        check_value("ctrl_word_valid", 64'(0), 64'(ctrl_word_valid));
        check_value("data_word_valid", 64'(0), 64'(data_word_valid));

        repeat (MIX1_CYCLES) step(60, 50);

        // fill with no pulls, stall has to hold the source
        stall_seen = 1'b0;
        repeat (FILL_CYCLES) step(100, 0);
        if (!stall_seen) begin
            other_cnt++;
            $display("stall never rose while the queues filled without pulls");
        end

        repeat (MIX2_CYCLES) step(50, 60);

        // drain, held word still goes in first
        while (!model_empty()) begin
            step(0, 100);
        end
        repeat (2) step(0, 0);
        check_value("rrsp_wd_stall", 64'(0), 64'(rrsp_wd_stall));
        check_value("ctrl_ready", 64'(0), 64'(ctrl_ready));
        check_value("data_ready", 64'(0), 64'(data_ready));
        if (same_q_pulls == 0 || diff_q_pulls == 0) begin
            other_cnt++;
            $display("parallel pulls to the same and to different queues were not both seen");
        end

        $display("errors: %0d mismatches, %0d other failures, %0d words checked",
                 mismatch_cnt, other_cnt, words_checked);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_tqu

/* hdl/egr_tqu_top.sv */
`timescale 1ns/1ps
`include "egr_tqu_defines.svh"

module egr_tqu_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // read response side
    input  logic                     rrsp_wd_valid,
    input  egr_rrsp_pkg::data_word_t rrsp_wd,
    input  egr_rrsp_pkg::word_type_e rrsp_wd_type,
    input  egr_rrsp_pkg::dtq_sel_t   rrsp_dtq,
    output logic                     rrsp_wd_stall,
    // pull side
    input  logic                     ctrl_pull,
    input  egr_rrsp_pkg::dtq_sel_t   ctrl_sel,
    input  logic                     data_pull,
    input  egr_rrsp_pkg::dtq_sel_t   data_sel,
    output logic [`EGR_N_DTQ-1:0]    ctrl_ready,
    output logic [`EGR_N_DTQ-1:0]    data_ready,
    output egr_rrsp_pkg::data_word_t ctrl_word,
    output egr_rrsp_pkg::data_word_t data_word,
    output logic                     ctrl_word_valid,
    output logic                     data_word_valid
);
    import egr_rrsp_pkg::*;
    import egr_buf_pkg::*;

    // --------------------
    // bank wiring
    // --------------------
    pkt_buf_addr_t ctrl_wr_addr;
    pkt_buf_addr_t ctrl_rd_addr;
    logic          ctrl_rd_en;
    logic          ctrl_wr_en;
    data_word_t    ctrl_wr_word;
    data_word_t    ctrl_rd_word;
    pkt_buf_addr_t data_wr_addr;
    pkt_buf_addr_t data_rd_addr;
    logic          data_rd_en;
    logic          data_wr_en;
    data_word_t    data_wr_word;
    data_word_t    data_rd_word;

    tqu u_tqu (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .rrsp_wd_valid         (rrsp_wd_valid),
        .rrsp_wd               (rrsp_wd),
        .rrsp_wd_type          (rrsp_wd_type),
        .rrsp_dtq              (rrsp_dtq),
        .rrsp_wd_stall         (rrsp_wd_stall),
        .ctrl_pull             (ctrl_pull),
        .ctrl_sel              (ctrl_sel),
        .data_pull             (data_pull),
        .data_sel              (data_sel),
        .ctrl_ready            (ctrl_ready),
        .data_ready            (data_ready),
        .ctrl_word             (ctrl_word),
        .data_word             (data_word),
        .ctrl_word_valid       (ctrl_word_valid),
        .data_word_valid       (data_word_valid),
        .pkt_buf_ctrl_wr_addr  (ctrl_wr_addr),
        .pkt_buf_ctrl_rd_addr  (ctrl_rd_addr),
        .pkt_buf_ctrl_rd_en    (ctrl_rd_en),
        .pkt_buf_ctrl_wr_en    (ctrl_wr_en),
        .pkt_buf_ctrl_word_out (ctrl_wr_word),
        .pkt_buf_ctrl_word_in  (ctrl_rd_word),
        .pkt_buf_data_wr_addr  (data_wr_addr),
        .pkt_buf_data_rd_addr  (data_rd_addr),
        .pkt_buf_data_rd_en    (data_rd_en),
        .pkt_buf_data_wr_en    (data_wr_en),
        .pkt_buf_data_word_out (data_wr_word),
        .pkt_buf_data_word_in  (data_rd_word)
    );

    // control words
    tqu_mem_bank ctrl_bank (
        .clk     (clk),
        .wr_en   (ctrl_wr_en),
        .wr_addr (ctrl_wr_addr),
        .wr_word (ctrl_wr_word),
        .rd_en   (ctrl_rd_en),
        .rd_addr (ctrl_rd_addr),
        .rd_word (ctrl_rd_word)
    );

    // data words
    tqu_mem_bank data_bank (
        .clk     (clk),
        .wr_en   (data_wr_en),
        .wr_addr (data_wr_addr),
        .wr_word (data_wr_word),
        .rd_en   (data_rd_en),
        .rd_addr (data_rd_addr),
        .rd_word (data_rd_word)
    );

endmodule : egr_tqu_top

/* hdl/tqu.sv */
`timescale 1ns/1ps
`include "egr_tqu_defines.svh"

module tqu (
    input  logic                       clk,
    input  logic                       rst_n,
    // read response side
    input  logic                       rrsp_wd_valid,
    input  egr_rrsp_pkg::data_word_t   rrsp_wd,
    input  egr_rrsp_pkg::word_type_e   rrsp_wd_type,
    input  egr_rrsp_pkg::dtq_sel_t     rrsp_dtq,
    output logic                       rrsp_wd_stall,
    // pull side
    input  logic                       ctrl_pull,
    input  egr_rrsp_pkg::dtq_sel_t     ctrl_sel,
    input  logic                       data_pull,
    input  egr_rrsp_pkg::dtq_sel_t     data_sel,
    output logic [`EGR_N_DTQ-1:0]      ctrl_ready,
    output logic [`EGR_N_DTQ-1:0]      data_ready,
    output egr_rrsp_pkg::data_word_t   ctrl_word,
    output egr_rrsp_pkg::data_word_t   data_word,
    output logic                       ctrl_word_valid,
    output logic                       data_word_valid,
    // control bank
    output egr_buf_pkg::pkt_buf_addr_t pkt_buf_ctrl_wr_addr,
    output egr_buf_pkg::pkt_buf_addr_t pkt_buf_ctrl_rd_addr,
    output logic                       pkt_buf_ctrl_rd_en,
    output logic                       pkt_buf_ctrl_wr_en,
    output egr_rrsp_pkg::data_word_t   pkt_buf_ctrl_word_out,
    input  egr_rrsp_pkg::data_word_t   pkt_buf_ctrl_word_in,
    // data bank
    output egr_buf_pkg::pkt_buf_addr_t pkt_buf_data_wr_addr,
    output egr_buf_pkg::pkt_buf_addr_t pkt_buf_data_rd_addr,
    output logic                       pkt_buf_data_rd_en,
    output logic                       pkt_buf_data_wr_en,
    output egr_rrsp_pkg::data_word_t   pkt_buf_data_word_out,
    input  egr_rrsp_pkg::data_word_t   pkt_buf_data_word_in
);
    import egr_rrsp_pkg::*;

    logic       ctrl_wr;
    logic       data_wr;
    dtq_sel_t   wr_dtq;
    data_word_t wr_word;

    // --------------------
    // receive
    // --------------------
    tqu_rrsp_rcv u_rrsp_rcv (
        .clk           (clk),
        .rst_n         (rst_n),
        .rrsp_wd_valid (rrsp_wd_valid),
        .rrsp_wd       (rrsp_wd),
        .rrsp_wd_type  (rrsp_wd_type),
        .rrsp_dtq      (rrsp_dtq),
        .rrsp_wd_stall (rrsp_wd_stall),
        .ctrl_wr       (ctrl_wr),
        .data_wr       (data_wr),
        .wr_dtq        (wr_dtq),
        .wr_word       (wr_word)
    );

    // --------------------
    // queue bookkeeping
    // --------------------
    tqu_queue_ctrl u_queue_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .ctrl_wr         (ctrl_wr),
        .data_wr         (data_wr),
        .wr_dtq          (wr_dtq),
        .ctrl_pull       (ctrl_pull),
        .data_pull       (data_pull),
        .ctrl_sel        (ctrl_sel),
        .data_sel        (data_sel),
        .ctrl_ready      (ctrl_ready),
        .data_ready      (data_ready),
        .ctrl_wr_addr    (pkt_buf_ctrl_wr_addr),
        .data_wr_addr    (pkt_buf_data_wr_addr),
        .ctrl_rd_addr    (pkt_buf_ctrl_rd_addr),
        .data_rd_addr    (pkt_buf_data_rd_addr),
        .ctrl_rd_en      (pkt_buf_ctrl_rd_en),
        .data_rd_en      (pkt_buf_data_rd_en),
        .ctrl_word_valid (ctrl_word_valid),
        .data_word_valid (data_word_valid),
        .rrsp_wd_stall   (rrsp_wd_stall)
    );

    // one held word feeds both banks, strobe picks the bank
    assign pkt_buf_ctrl_wr_en    = ctrl_wr;
    assign pkt_buf_data_wr_en    = data_wr;
    assign pkt_buf_ctrl_word_out = wr_word;
    assign pkt_buf_data_word_out = wr_word;

    // registered bank reads come back as pulled words
    assign ctrl_word = pkt_buf_ctrl_word_in;
    assign data_word = pkt_buf_data_word_in;

endmodule : tqu

/* hdl/tqu_queue_ctrl.sv */
`timescale 1ns/1ps
`include "egr_tqu_defines.svh"

module tqu_queue_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    // write strobes from the receiver
    input  logic                       ctrl_wr,
    input  logic                       data_wr,
    input  egr_rrsp_pkg::dtq_sel_t     wr_dtq,
    // pull side
    input  logic                       ctrl_pull,
    input  logic                       data_pull,
    input  egr_rrsp_pkg::dtq_sel_t     ctrl_sel,
    input  egr_rrsp_pkg::dtq_sel_t     data_sel,
    output logic [`EGR_N_DTQ-1:0]      ctrl_ready,
    output logic [`EGR_N_DTQ-1:0]      data_ready,
    // bank addressing
    output egr_buf_pkg::pkt_buf_addr_t ctrl_wr_addr,
    output egr_buf_pkg::pkt_buf_addr_t data_wr_addr,
    output egr_buf_pkg::pkt_buf_addr_t ctrl_rd_addr,
    output egr_buf_pkg::pkt_buf_addr_t data_rd_addr,
    output logic                       ctrl_rd_en,
    output logic                       data_rd_en,
    output logic                       ctrl_word_valid,
    output logic                       data_word_valid,
    // back-pressure toward the read response source
    output logic                       rrsp_wd_stall
);
    import egr_rrsp_pkg::*;
    import egr_buf_pkg::*;

    // bank 0 is control, bank 1 is data
    localparam int N_BANKS = 2;

    // per bank views of the ports
    logic                  wr_b       [N_BANKS];
    logic                  pull_b     [N_BANKS];
    dtq_sel_t              sel_b      [N_BANKS];
    logic [`EGR_N_DTQ-1:0] ready_b    [N_BANKS];
    logic [`EGR_N_DTQ-1:0] low_b      [N_BANKS];
    pkt_buf_addr_t         wr_addr_b  [N_BANKS];
    pkt_buf_addr_t         rd_addr_b  [N_BANKS];
    q_ptr_t                head_q     [N_BANKS][`EGR_N_DTQ];
    q_ptr_t                tail_q     [N_BANKS][`EGR_N_DTQ];

    assign wr_b[0]   = ctrl_wr;
    assign wr_b[1]   = data_wr;
    assign pull_b[0] = ctrl_pull;
    assign pull_b[1] = data_pull;
    assign sel_b[0]  = ctrl_sel;
    assign sel_b[1]  = data_sel;

    // --------------------
    // per queue state
    // --------------------
    for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
        for (genvar q = 0; q < `EGR_N_DTQ; q++) begin : g_q
            q_ptr_t head;
            q_ptr_t tail;
            q_cnt_t cnt;
            logic   q_wr;
            logic   q_pull;

            assign q_wr   = wr_b[b] && (wr_dtq == dtq_sel_t'(q));
            assign q_pull = pull_b[b] && (sel_b[b] == dtq_sel_t'(q));

            // write and pull on same queue both land, count nets out
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    head <= '0;
                    tail <= '0;
                    cnt  <= '0;
                end else begin
                    if (q_wr) begin
                        tail <= q_ptr_t'(tail + 1'b1);
                    end
                    if (q_pull) begin
                        head <= q_ptr_t'(head + 1'b1);
                    end
                    cnt <= q_cnt_t'(cnt + q_cnt_t'(q_wr) - q_cnt_t'(q_pull));
                end
            end

            assign head_q[b][q] = head;
            assign tail_q[b][q] = tail;

            // ready straight from the count
            assign ready_b[b][q] = (cnt != '0);

            // free entries after the strobe now in flight
            assign low_b[b][q] = (int'(`EGR_Q_DEPTH) - int'(cnt) - int'(q_wr))
                                 < `EGR_STALL_MARGIN;

            // stall must keep every queue within its depth
            a_cnt_bound : assert property (
                @(posedge clk) disable iff (!rst_n)
                cnt <= q_cnt_t'(`EGR_Q_DEPTH)
            );
        end

        // --------------------
        // addressing
        // --------------------
        // queue number times depth plus pointer, depth is a power of two
        assign wr_addr_b[b] = {wr_dtq, tail_q[b][wr_dtq]};
        assign rd_addr_b[b] = {sel_b[b], head_q[b][sel_b[b]]};

        // transmit controller only pulls ready queues
        a_pull_ready : assert property (
            @(posedge clk) disable iff (!rst_n)
            pull_b[b] |-> ready_b[b][sel_b[b]]
        );
    end

    assign ctrl_ready   = ready_b[0];
    assign data_ready   = ready_b[1];
    assign ctrl_wr_addr = wr_addr_b[0];
    assign data_wr_addr = wr_addr_b[1];
    assign ctrl_rd_addr = rd_addr_b[0];
    assign data_rd_addr = rd_addr_b[1];

    // read enable in the pull cycle itself
    assign ctrl_rd_en = ctrl_pull;
    assign data_rd_en = data_pull;

    // --------------------
    // valids and stall
    // --------------------
    // valid lines up with the bank's registered read word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_word_valid <= 1'b0;
            data_word_valid <= 1'b0;
            rrsp_wd_stall   <= 1'b0;
        end else begin
            ctrl_word_valid <= ctrl_pull;
            data_word_valid <= data_pull;
            // any short queue in either bank holds the source
            rrsp_wd_stall   <= (|low_b[0]) || (|low_b[1]);
        end
    end

endmodule : tqu_queue_ctrl

/* hdl/tqu_rrsp_rcv.sv */
`timescale 1ns/1ps

module tqu_rrsp_rcv (
    input  logic                     clk,
    input  logic                     rst_n,
    // read response side
    input  logic                     rrsp_wd_valid,
    input  egr_rrsp_pkg::data_word_t rrsp_wd,
    input  egr_rrsp_pkg::word_type_e rrsp_wd_type,
    input  egr_rrsp_pkg::dtq_sel_t   rrsp_dtq,
    // registered stall from queue controller
    input  logic                     rrsp_wd_stall,
    // write strobes toward the banks
    output logic                     ctrl_wr,
    output logic                     data_wr,
    output egr_rrsp_pkg::dtq_sel_t   wr_dtq,
    output egr_rrsp_pkg::data_word_t wr_word
);
    import egr_rrsp_pkg::*;

    logic accept;
    logic is_ctrl;
    logic is_data;

    // --------------------
    // acceptance and decode
    // --------------------

    // word taken on an edge with valid high and stall low
    assign accept = rrsp_wd_valid && !rrsp_wd_stall;

    // steer by word type
    assign is_ctrl = accept && (rrsp_wd_type == WORD_TYPE_CTRL);
    assign is_data = accept && (rrsp_wd_type == WORD_TYPE_DATA);

    // --------------------
    // write strobes
    // --------------------

    // one cycle pulse per accepted word
    // at most one of the two is high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_wr <= 1'b0;
            data_wr <= 1'b0;
        end else begin
            ctrl_wr <= is_ctrl;
            data_wr <= is_data;
        end
    end

    // --------------------
    // hold registers
    // --------------------

    // word and queue only move on acceptance
    // otherwise they keep the last accepted word
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_word <= rrsp_wd;
            wr_dtq  <= rrsp_dtq;
        end
    end

    // --------------------
    // checks
    // --------------------

    // source must present a known type with every valid word,
    // else the word would land in neither bank and be lost
    a_type_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        rrsp_wd_valid |-> !$isunknown(rrsp_wd_type)
    );

endmodule : tqu_rrsp_rcv

/* hdl/tqu_mem_bank.sv */
`timescale 1ns/1ps
`include "egr_tqu_defines.svh"

module tqu_mem_bank (
    input  logic                       clk,
    // write port
    input  logic                       wr_en,
    input  egr_buf_pkg::pkt_buf_addr_t wr_addr,
    input  egr_rrsp_pkg::data_word_t   wr_word,
    // read port
    input  logic                       rd_en,
    input  egr_buf_pkg::pkt_buf_addr_t rd_addr,
    output egr_rrsp_pkg::data_word_t   rd_word
);
    import egr_rrsp_pkg::*;

    // all queues of one bank share this array
    localparam int N_ENTRIES = `EGR_N_DTQ * `EGR_Q_DEPTH;

    data_word_t mem [N_ENTRIES];

    // --------------------
    // write side
    // --------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // --------------------
    // read side
    // --------------------
    // registered read, word shows one cycle after rd_en
    // holds last word while idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

endmodule : tqu_mem_bank

/* hdl/egr_buf_pkg.sv */
`include "egr_tqu_defines.svh"

// --------------------
// packet buffer types
// --------------------
package egr_buf_pkg;

    // bank address, queue number in the upper bits, pointer in the lower
    typedef logic [$clog2(`EGR_N_DTQ * `EGR_Q_DEPTH)-1:0] pkt_buf_addr_t;

    // head or tail pointer inside one queue
    typedef logic [$clog2(`EGR_Q_DEPTH)-1:0] q_ptr_t;

    // occupancy, needs one bit more than the pointer to hold a full queue
    typedef logic [$clog2(`EGR_Q_DEPTH):0] q_cnt_t;

endpackage : egr_buf_pkg

/* hdl/egr_rrsp_pkg.sv */
`include "egr_tqu_defines.svh"

// --------------------
// read response word types
// --------------------
package egr_rrsp_pkg;

    // word type carried with every read response word
    // control words go to the control bank, data words to the data bank
    typedef enum logic {
        WORD_TYPE_CTRL = 1'b0,
        WORD_TYPE_DATA = 1'b1
    } word_type_e;

    // one packet buffer word
    typedef logic [`EGR_WORD_W-1:0] data_word_t;

    // destination transmit queue select
    typedef logic [$clog2(`EGR_N_DTQ)-1:0] dtq_sel_t;

endpackage : egr_rrsp_pkg

/* include/egr_tqu_defines.svh */
`ifndef EGR_TQU_DEFINES_SVH
`define EGR_TQU_DEFINES_SVH

// --------------------
// tag queuing sizes
// --------------------

// transmit queues per bank
`define EGR_N_DTQ 4

// packet buffer word width
`define EGR_WORD_W 64

// entries per queue, per bank
`define EGR_Q_DEPTH 8

// free entries below which stall rises
// covers the write strobe in flight plus the word being accepted
`define EGR_STALL_MARGIN 2

`endif
